//--- filelist.f
+incdir+logic
+incdir+tests
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_mult.sv
logic/div_fsm.sv
logic/div_step_counter.sv
logic/div_datapath.sv
logic/ex_stage.sv
tests/ex_stage_tb.sv

//--- logic/div_datapath.sv
// Restoring divider datapath; operands must be stable in LOAD, result valid only in DONE
`include "exec_settings.svh"

module div_datapath (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exec_pkg::div_state_e   state_i,
  input  exec_pkg::div_op_e      op_i,
  input  logic [`EXEC_XLEN-1:0]  op_a_i,
  input  logic [`EXEC_XLEN-1:0]  op_b_i,
  output logic [`EXEC_XLEN-1:0]  result_o
);

  localparam int XLEN = `EXEC_XLEN;

  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  // Step signals
  logic [XLEN:0]   rem_shift;
  logic [XLEN:0]   trial;
  logic            fits;

  // Operation flags, captured in LOAD
  logic            quo_neg_q;
  logic            rem_neg_q;
  logic            div0_q;
  logic            rem_sel_q;

  // Working registers
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] quo_q;
  logic [XLEN-1:0] divisor_q;

  logic [XLEN-1:0] quo_fixed;
  logic [XLEN-1:0] rem_fixed;

  ////////////////////
  // Operand magnitudes
  ////////////////////

  assign is_signed = (op_i == exec_pkg::DIV) || (op_i == exec_pkg::REM);
  assign a_neg     = is_signed && op_a_i[XLEN-1];
  assign b_neg     = is_signed && op_b_i[XLEN-1];
  // Most negative value maps to 2^(XLEN-1) unsigned
  assign a_mag     = a_neg ? (~op_a_i + 1'b1) : op_a_i;
  assign b_mag     = b_neg ? (~op_b_i + 1'b1) : op_b_i;

  ////////////////////
  // Shift-subtract step
  ////////////////////

  // Next dividend bit enters the partial remainder
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign trial     = rem_shift - {1'b0, divisor_q};
  assign fits      = (rem_shift >= {1'b0, divisor_q});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quo_neg_q <= 1'b0;
      rem_neg_q <= 1'b0;
      div0_q    <= 1'b0;
      rem_sel_q <= 1'b0;
    end else if (state_i == exec_pkg::LOAD) begin
      quo_neg_q <= a_neg ^ b_neg;
      // Remainder takes the dividend sign
      rem_neg_q <= a_neg;
      div0_q    <= (op_b_i == '0);
      rem_sel_q <= (op_i == exec_pkg::REM) || (op_i == exec_pkg::REMU);
    end
  end

  always_ff @(posedge clk) begin
    if (state_i == exec_pkg::LOAD) begin
      rem_q     <= '0;
      // Quotient register starts out holding the dividend
      quo_q     <= a_mag;
      divisor_q <= b_mag;
    end else if (state_i == exec_pkg::ITER) begin
      rem_q     <= fits ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];
      quo_q     <= {quo_q[XLEN-2:0], fits};
    end
  end

  ////////////////////
  // Result with sign fix
  ////////////////////

  // Zero divisor gives all ones; remainder already equals the dividend magnitude
  assign quo_fixed = div0_q    ? '1
                   : quo_neg_q ? (~quo_q + 1'b1) : quo_q;
  assign rem_fixed = rem_neg_q ? (~rem_q + 1'b1) : rem_q;

  assign result_o  = rem_sel_q ? rem_fixed : quo_fixed;

endmodule

//--- logic/div_fsm.sv
// Divider control; valid_i must stay high for the whole division, a low level aborts it
module div_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid_i,
  input  logic                   ready_i,
  input  logic                   last_step_i,
  output exec_pkg::div_state_e   state_o,
  output logic                   valid_o,
  output logic                   ready_o
);

  exec_pkg::div_state_e state_q;
  exec_pkg::div_state_e state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      exec_pkg::IDLE: begin
        if (valid_i) begin
          state_d = exec_pkg::LOAD;
        end
      end
      // Operands captured here
      exec_pkg::LOAD: state_d = exec_pkg::ITER;
      exec_pkg::ITER: begin
        if (last_step_i) begin
          state_d = exec_pkg::DONE;
        end
      end
      // Hold result until WB takes it
      exec_pkg::DONE: begin
        if (ready_i) begin
          state_d = exec_pkg::IDLE;
        end
      end
      default: state_d = exec_pkg::IDLE;
    endcase
    // Kill or halt aborts from any state
    if (!valid_i) begin
      state_d = exec_pkg::IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exec_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;
  assign valid_o = (state_q == exec_pkg::DONE);
  assign ready_o = ((state_q == exec_pkg::IDLE) && !valid_i) ||
                   ((state_q == exec_pkg::DONE) && ready_i);

endmodule

//--- logic/div_step_counter.sv
// Counts EXEC_DIV_STEPS iterate cycles; last_step_o is only meaningful in ITER
`include "exec_settings.svh"

module div_step_counter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exec_pkg::div_state_e   state_i,
  output logic                   last_step_o
);

  localparam int CNT_W = $clog2(`EXEC_DIV_STEPS);

  logic [CNT_W-1:0] cnt_q;

  // Load in LOAD, count down in ITER
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (state_i == exec_pkg::LOAD) begin
      cnt_q <= CNT_W'(`EXEC_DIV_STEPS - 1);
    end else if ((state_i == exec_pkg::ITER) && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_step_o = (cnt_q == '0);

endmodule

//--- logic/ex_stage.sv
// Execute stage top; ID must hold id_ex_pipe_i until ex_ready_o, one instruction in flight
`include "exec_settings.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // ID/EX pipeline
  input  exec_pkg::id_ex_pipe_t  id_ex_pipe_i,
  // Controller
  input  exec_pkg::ctrl_fsm_t    ctrl_fsm_i,
  input  logic                   wb_ready_i,
  // EX/WB pipeline
  output exec_pkg::ex_wb_pipe_t  ex_wb_pipe_o,
  // Forwarding and branch to earlier stages
  output logic [`EXEC_XLEN-1:0]  rf_wdata_o,
  output logic                   branch_decision_o,
  // Stage handshake
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic                  instr_live;
  logic                  mul_en_gated;
  logic                  div_en_gated;

  // ALU
  logic [`EXEC_XLEN-1:0] alu_result;
  logic                  alu_cmp_result;

  // Multiplier
  logic [`EXEC_XLEN-1:0] mul_result;
  logic                  mul_valid;
  logic                  mul_ready;

  // Divider
  exec_pkg::div_state_e  div_state;
  logic                  div_last_step;
  logic [`EXEC_XLEN-1:0] div_result;
  logic                  div_valid;
  logic                  div_ready;

  // Live unless killed or halted
  assign instr_live   = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;

  // Dropping the enable aborts a multi-cycle op
  assign mul_en_gated = id_ex_pipe_i.mul_en && instr_live;
  assign div_en_gated = id_ex_pipe_i.div_en && instr_live;

  ////////////////////
  // ALU
  ////////////////////

  exec_alu alu0 (
    .op_i         (id_ex_pipe_i.alu_op),
    .operand_a_i  (id_ex_pipe_i.operand_a),
    .operand_b_i  (id_ex_pipe_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  assign branch_decision_o = alu_cmp_result;

  ////////////////////
  // Multiplier
  ////////////////////

  exec_mult mult0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_i     (id_ex_pipe_i.mul_op),
    .op_a_i   (id_ex_pipe_i.operand_a),
    .op_b_i   (id_ex_pipe_i.operand_b),
    .valid_i  (mul_en_gated),
    .ready_i  (wb_ready_i),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_o  (mul_ready)
  );

  ////////////////////
  // Divider
  ////////////////////

  div_fsm div_fsm0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (div_en_gated),
    .ready_i     (wb_ready_i),
    .last_step_i (div_last_step),
    .state_o     (div_state),
    .valid_o     (div_valid),
    .ready_o     (div_ready)
  );

  div_step_counter div_cnt0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_i     (div_state),
    .last_step_o (div_last_step)
  );

  div_datapath div_dp0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .state_i  (div_state),
    .op_i     (id_ex_pipe_i.div_op),
    .op_a_i   (id_ex_pipe_i.operand_a),
    .op_b_i   (id_ex_pipe_i.operand_b),
    .result_o (div_result)
  );

  // Write data picked by the one-hot unit enable with the ALU as default
  always_comb begin
    unique case (1'b1)
      id_ex_pipe_i.mul_en: rf_wdata_o = mul_result;
      id_ex_pipe_i.div_en: rf_wdata_o = div_result;
      default:             rf_wdata_o = alu_result;
    endcase
  end

  ////////////////////
  // Stage handshake
  ////////////////////

  // Kill always frees the stage; ALU is never the bottleneck
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (mul_ready && div_ready && wb_ready_i && !ctrl_fsm_i.halt_ex);

  // Illegal instructions pass on as a bubble-free flag
  assign ex_valid_o = instr_live &&
                      (id_ex_pipe_i.alu_en                 ||
                       (id_ex_pipe_i.mul_en && mul_valid)  ||
                       (id_ex_pipe_i.div_en && div_valid)  ||
                       id_ex_pipe_i.illegal_insn);

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_pipe_o <= '0;
    end else if (ex_valid_o && wb_ready_i) begin
      ex_wb_pipe_o.instr_valid  <= 1'b1;
      // No register write for an illegal instruction
      ex_wb_pipe_o.rf_we        <= id_ex_pipe_i.rf_we && !id_ex_pipe_i.illegal_insn;
      if (id_ex_pipe_i.rf_we) begin
        ex_wb_pipe_o.rf_waddr   <= id_ex_pipe_i.rf_waddr;
        ex_wb_pipe_o.rf_wdata   <= rf_wdata_o;
      end
      ex_wb_pipe_o.pc           <= id_ex_pipe_i.pc;
      ex_wb_pipe_o.illegal_insn <= id_ex_pipe_i.illegal_insn;
    end else if (wb_ready_i) begin
      // Bubble keeps the payload
      ex_wb_pipe_o.instr_valid  <= 1'b0;
    end
  end

endmodule

//--- logic/exec_alu.sv
// Single-cycle ALU; shift amount is the low log2(EXEC_XLEN) bits of operand b, as in RV32I
`include "exec_settings.svh"

module exec_alu (
  input  exec_pkg::alu_op_e      op_i,
  input  logic [`EXEC_XLEN-1:0]  operand_a_i,
  input  logic [`EXEC_XLEN-1:0]  operand_b_i,
  output logic [`EXEC_XLEN-1:0]  result_o,
  output logic                   cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               is_eq;
  logic               lt_s;
  logic               lt_u;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Shared comparators for slt/sltu and branches
  assign is_eq = (operand_a_i == operand_b_i);
  assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u  = (operand_a_i < operand_b_i);

  // Branch decision, low for non-branch ops
  always_comb begin
    unique case (op_i)
      exec_pkg::ALU_EQ:  cmp_result_o = is_eq;
      exec_pkg::ALU_NE:  cmp_result_o = !is_eq;
      exec_pkg::ALU_LT:  cmp_result_o = lt_s;
      exec_pkg::ALU_GE:  cmp_result_o = !lt_s;
      exec_pkg::ALU_LTU: cmp_result_o = lt_u;
      exec_pkg::ALU_GEU: cmp_result_o = !lt_u;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  // Result word
  always_comb begin
    unique case (op_i)
      exec_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      exec_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      exec_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      exec_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      exec_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      exec_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      exec_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      exec_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      exec_pkg::ALU_SLT:  result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
      exec_pkg::ALU_SLTU: result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
      // Branch ops return the compare bit zero-extended
      default:            result_o = {{(`EXEC_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- logic/exec_mult.sv
// Two-cycle unsigned multiplier; operands are sampled on the first edge only, no signed high word
`include "exec_settings.svh"

module exec_mult (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exec_pkg::mul_op_e      op_i,
  input  logic [`EXEC_XLEN-1:0]  op_a_i,
  input  logic [`EXEC_XLEN-1:0]  op_b_i,
  input  logic                   valid_i,
  input  logic                   ready_i,
  output logic [`EXEC_XLEN-1:0]  result_o,
  output logic                   valid_o,
  output logic                   ready_o
);

  logic [2*`EXEC_XLEN-1:0] product;
  logic [`EXEC_XLEN-1:0]   result_q;
  logic                    busy_q;

  // Full unsigned product
  assign product = {{`EXEC_XLEN{1'b0}}, op_a_i} * {{`EXEC_XLEN{1'b0}}, op_b_i};

  // Busy while a result waits for WB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      // Taken by WB, or dropped by kill/halt
      if (ready_i || !valid_i) begin
        busy_q <= 1'b0;
      end
    end else if (valid_i) begin
      busy_q <= 1'b1;
    end
  end

  // Selected half captured on the first edge
  always_ff @(posedge clk) begin
    if (!busy_q && valid_i) begin
      result_q <= (op_i == exec_pkg::MULHU) ? product[2*`EXEC_XLEN-1:`EXEC_XLEN]
                                            : product[`EXEC_XLEN-1:0];
    end
  end

  assign result_o = result_q;
  assign valid_o  = busy_q;
  assign ready_o  = (!busy_q && !valid_i) || (busy_q && ready_i);

endmodule

//--- logic/exec_pkg.sv
// Shared types of the execute stage; field widths come from exec_settings.svh
`include "exec_settings.svh"

package exec_pkg;

  ////////////////////
  // Operators
  ////////////////////

  // ALU operator, all 16 codes used
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch compares
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operator, low or unsigned high word
  typedef enum logic {
    MUL   = 1'b0,
    MULHU = 1'b1
  } mul_op_e;

  // Divider operator
  typedef enum logic [1:0] {
    DIV  = 2'd0,
    DIVU = 2'd1,
    REM  = 2'd2,
    REMU = 2'd3
  } div_op_e;

  // Divider control states, also the datapath step enables
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    LOAD = 3'd1,
    ITER = 3'd2,
    DONE = 3'd3
  } div_state_e;

  ////////////////////
  // Pipeline structs
  ////////////////////

  // ID/EX, one instruction
  typedef struct packed {
    logic                    instr_valid;
    logic                    alu_en;
    logic                    mul_en;
    logic                    div_en;
    alu_op_e                 alu_op;
    mul_op_e                 mul_op;
    div_op_e                 div_op;
    logic [`EXEC_XLEN-1:0]   operand_a;
    logic [`EXEC_XLEN-1:0]   operand_b;
    logic                    rf_we;
    logic [`EXEC_REG_AW-1:0] rf_waddr;
    logic [`EXEC_XLEN-1:0]   pc;
    logic                    illegal_insn;
  } id_ex_pipe_t;

  // EX/WB, registered result
  typedef struct packed {
    logic                    instr_valid;
    logic                    rf_we;
    logic [`EXEC_REG_AW-1:0] rf_waddr;
    logic [`EXEC_XLEN-1:0]   rf_wdata;
    logic [`EXEC_XLEN-1:0]   pc;
    logic                    illegal_insn;
  } ex_wb_pipe_t;

  // Controller requests to EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_fsm_t;

endpackage

//--- logic/exec_settings.svh
// Widths for the execute stage; EXEC_DIV_STEPS must equal EXEC_XLEN for the restoring divider
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////

// Operand and result width
`define EXEC_XLEN 32

// Register file address width
`define EXEC_REG_AW 5

////////////////////
// Divider
////////////////////

// One quotient bit per iterate cycle
`define EXEC_DIV_STEPS `EXEC_XLEN

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f filelist.f \
  --top-module ex_stage_tb \
  -Mdir obj_dir

./obj_dir/Vex_stage_tb

//--- tests/ex_stage_vectors.svh
// Directed vectors written for EXEC_XLEN = 32; unit 3 is an illegal instruction on the ALU path
`ifndef EX_STAGE_VECTORS_SVH
`define EX_STAGE_VECTORS_SVH

// Unit select of a row
localparam logic [1:0] U_ALU = 2'd0;
localparam logic [1:0] U_MUL = 2'd1;
localparam logic [1:0] U_DIV = 2'd2;
localparam logic [1:0] U_ILL = 2'd3;

// One row of stimulus with its expected response
typedef struct packed {
  logic [1:0]            unit;
  logic [3:0]            op;
  logic [`EXEC_XLEN-1:0] a;
  logic [`EXEC_XLEN-1:0] b;
  logic [3:0]            stall;
  logic                  kill;
  logic [`EXEC_XLEN-1:0] exp_wdata;
  logic                  exp_branch;
} vec_t;

localparam int NUM_VEC = 37;

// unit, op, operand a, operand b, wb stall cycles, kill, expected rf_wdata, expected branch
localparam vec_t VECS [NUM_VEC] = '{
  '{U_ALU, 4'd0,  32'h0000_0005, 32'hFFFF_FFFE, 4'd0, 1'b0, 32'h0000_0003, 1'b0},
  '{U_ALU, 4'd1,  32'h0000_0003, 32'h0000_0005, 4'd0, 1'b0, 32'hFFFF_FFFE, 1'b0},
  '{U_ALU, 4'd2,  32'hF0F0_1234, 32'h0FF0_FF00, 4'd0, 1'b0, 32'h00F0_1200, 1'b0},
  '{U_ALU, 4'd3,  32'hF000_000F, 32'h0000_FF00, 4'd0, 1'b0, 32'hF000_FF0F, 1'b0},
  '{U_ALU, 4'd4,  32'hAAAA_5555, 32'hFFFF_0000, 4'd0, 1'b0, 32'h5555_5555, 1'b0},
  // Shift amount 36 wraps to 4
  '{U_ALU, 4'd5,  32'h0000_0001, 32'h0000_0024, 4'd0, 1'b0, 32'h0000_0010, 1'b0},
  '{U_ALU, 4'd6,  32'h8000_0000, 32'h0000_0004, 4'd0, 1'b0, 32'h0800_0000, 1'b0},
  '{U_ALU, 4'd7,  32'h8000_0000, 32'h0000_0004, 4'd0, 1'b0, 32'hF800_0000, 1'b0},
  '{U_ALU, 4'd8,  32'hFFFF_FFFF, 32'h0000_0001, 4'd0, 1'b0, 32'h0000_0001, 1'b0},
  '{U_ALU, 4'd9,  32'hFFFF_FFFF, 32'h0000_0001, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  // Branch compares give the compare bit as result word
  '{U_ALU, 4'd10, 32'h0000_1234, 32'h0000_1234, 4'd0, 1'b0, 32'h0000_0001, 1'b1},
  '{U_ALU, 4'd11, 32'h0000_1234, 32'h0000_1234, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  '{U_ALU, 4'd12, 32'hFFFF_FFF0, 32'h0000_0005, 4'd0, 1'b0, 32'h0000_0001, 1'b1},
  '{U_ALU, 4'd13, 32'hFFFF_FFF0, 32'h0000_0005, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  '{U_ALU, 4'd14, 32'hFFFF_FFF0, 32'h0000_0005, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  '{U_ALU, 4'd15, 32'hFFFF_FFF0, 32'h0000_0005, 4'd0, 1'b0, 32'h0000_0001, 1'b1},
  '{U_ALU, 4'd0,  32'h7FFF_FFFF, 32'h0000_0001, 4'd3, 1'b0, 32'h8000_0000, 1'b0},
  // mul and mulhu
  '{U_MUL, 4'd0,  32'h0001_0000, 32'h0001_0000, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  '{U_MUL, 4'd1,  32'h0001_0000, 32'h0001_0000, 4'd0, 1'b0, 32'h0000_0001, 1'b0},
  '{U_MUL, 4'd0,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd0, 1'b0, 32'h0000_0001, 1'b0},
  '{U_MUL, 4'd1,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd2, 1'b0, 32'hFFFF_FFFE, 1'b0},
  '{U_MUL, 4'd0,  32'h0000_1234, 32'h0000_0100, 4'd0, 1'b0, 32'h0012_3400, 1'b0},
  // div 0, divu 1, rem 2, remu 3
  '{U_DIV, 4'd0,  32'hFFFF_FFF9, 32'h0000_0002, 4'd0, 1'b0, 32'hFFFF_FFFD, 1'b0},
  '{U_DIV, 4'd2,  32'hFFFF_FFF9, 32'h0000_0002, 4'd0, 1'b0, 32'hFFFF_FFFF, 1'b0},
  '{U_DIV, 4'd1,  32'hFFFF_FFF9, 32'h0000_0002, 4'd0, 1'b0, 32'h7FFF_FFFC, 1'b0},
  '{U_DIV, 4'd3,  32'hFFFF_FFF9, 32'h0000_0002, 4'd0, 1'b0, 32'h0000_0001, 1'b0},
  // Zero divisor
  '{U_DIV, 4'd0,  32'h0000_0064, 32'h0000_0000, 4'd0, 1'b0, 32'hFFFF_FFFF, 1'b0},
  '{U_DIV, 4'd0,  32'hFFFF_FF9C, 32'h0000_0000, 4'd0, 1'b0, 32'hFFFF_FFFF, 1'b0},
  '{U_DIV, 4'd2,  32'hFFFF_FF9C, 32'h0000_0000, 4'd0, 1'b0, 32'hFFFF_FF9C, 1'b0},
  '{U_DIV, 4'd1,  32'h1234_5678, 32'h0000_0000, 4'd0, 1'b0, 32'hFFFF_FFFF, 1'b0},
  '{U_DIV, 4'd3,  32'h1234_5678, 32'h0000_0000, 4'd0, 1'b0, 32'h1234_5678, 1'b0},
  // Signed overflow
  '{U_DIV, 4'd0,  32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 1'b0, 32'h8000_0000, 1'b0},
  '{U_DIV, 4'd2,  32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 1'b0, 32'h0000_0000, 1'b0},
  // Division killed midway and the clean ones after it
  '{U_DIV, 4'd0,  32'h0000_0064, 32'h0000_0007, 4'd0, 1'b1, 32'h0000_0000, 1'b0},
  '{U_DIV, 4'd1,  32'h0000_0064, 32'h0000_0007, 4'd0, 1'b0, 32'h0000_000E, 1'b0},
  '{U_DIV, 4'd2,  32'h0000_0064, 32'hFFFF_FFF9, 4'd4, 1'b0, 32'h0000_0002, 1'b0},
  '{U_ILL, 4'd0,  32'h0000_0005, 32'h0000_0006, 4'd0, 1'b0, 32'h0000_000B, 1'b0}
};

`endif

//--- tests/ex_stage_tb.sv
// Self-checking testbench for ex_stage; the directed table assumes a 32-bit datapath
`include "exec_settings.svh"

module ex_stage_tb;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_RAND       = 40;
  localparam int CYCLES_PER_VEC = 45;
  // Cycles into a division before the kill
  localparam int KILL_DELAY     = 5;
  localparam int KILL_WAIT      = `EXEC_DIV_STEPS + 8;

  `include "ex_stage_vectors.svh"

  localparam int WATCHDOG_TIME  = (NUM_VEC + NUM_RAND) * CYCLES_PER_VEC * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  exec_pkg::id_ex_pipe_t id_ex_pipe_i;
  exec_pkg::ctrl_fsm_t   ctrl_fsm_i;
  logic                  wb_ready_i;
  exec_pkg::ex_wb_pipe_t ex_wb_pipe_o;
  logic [`EXEC_XLEN-1:0] rf_wdata_o;
  logic                  branch_decision_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;

  integer                seed;

  ex_stage dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe_i),
    .ctrl_fsm_i        (ctrl_fsm_i),
    .wb_ready_i        (wb_ready_i),
    .ex_wb_pipe_o      (ex_wb_pipe_o),
    .rf_wdata_o        (rf_wdata_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run length bound
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired: the execute stage stopped responding");
    $display("FAIL: see errors above");
    $fatal(1, "run aborted by watchdog");
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_wb(input exec_pkg::ex_wb_pipe_t got, input exec_pkg::ex_wb_pipe_t exp,
                          input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got v=%0b we=%0b wa=%0d wd=%h pc=%h ill=%0b", $time, what,
               got.instr_valid, got.rf_we, got.rf_waddr, got.rf_wdata, got.pc, got.illegal_insn);
      $display("  expected v=%0b we=%0b wa=%0d wd=%h pc=%h ill=%0b", exp.instr_valid, exp.rf_we,
               exp.rf_waddr, exp.rf_wdata, exp.pc, exp.illegal_insn);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_branch(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0b expected %0b", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Forwarded write data
  task automatic check_wdata(input logic [`EXEC_XLEN-1:0] got,
                             input logic [`EXEC_XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Handshake and valid bits
  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0b expected %0b", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  ////////////////////
  // Stimulus and model
  ////////////////////

  // Destination and pc follow the row number
  function automatic logic [`EXEC_REG_AW-1:0] row_waddr(input int idx);
    return `EXEC_REG_AW'(idx % 31 + 1);
  endfunction

  function automatic logic [`EXEC_XLEN-1:0] row_pc(input int idx);
    return `EXEC_XLEN'(32'h0000_1000 + idx * 4);
  endfunction

  function automatic exec_pkg::id_ex_pipe_t make_pipe(input vec_t v, input int idx);
    exec_pkg::id_ex_pipe_t p;
    p              = '0;
    p.instr_valid  = 1'b1;
    p.alu_en       = (v.unit == U_ALU);
    p.mul_en       = (v.unit == U_MUL);
    p.div_en       = (v.unit == U_DIV);
    p.illegal_insn = (v.unit == U_ILL);
    if (v.unit == U_MUL) begin
      p.mul_op = exec_pkg::mul_op_e'(v.op[0]);
    end else if (v.unit == U_DIV) begin
      p.div_op = exec_pkg::div_op_e'(v.op[1:0]);
    end else begin
      p.alu_op = exec_pkg::alu_op_e'(v.op);
    end
    p.operand_a    = v.a;
    p.operand_b    = v.b;
    p.rf_we        = 1'b1;
    p.rf_waddr     = row_waddr(idx);
    p.pc           = row_pc(idx);
    return p;
  endfunction

  // Illegal instructions land with the write enable dropped
  function automatic exec_pkg::ex_wb_pipe_t expected_wb(input vec_t v, input int idx);
    exec_pkg::ex_wb_pipe_t e;
    e.instr_valid  = 1'b1;
    e.rf_we        = (v.unit != U_ILL);
    e.rf_waddr     = row_waddr(idx);
    e.rf_wdata     = v.exp_wdata;
    e.pc           = row_pc(idx);
    e.illegal_insn = (v.unit == U_ILL);
    return e;
  endfunction

  // add, xor, mul, divu
  function automatic logic [`EXEC_XLEN-1:0] ref_result(input logic [1:0] kind,
                                                       input logic [`EXEC_XLEN-1:0] a,
                                                       input logic [`EXEC_XLEN-1:0] b);
    case (kind)
      2'd0:    return a + b;
      2'd1:    return a ^ b;
      // Low word of the product is the product modulo 2^XLEN
      2'd2:    return a * b;
      default: return (b == '0) ? '1 : a / b;
    endcase
  endfunction

  function automatic vec_t random_row(input logic [1:0] kind, input logic [`EXEC_XLEN-1:0] a,
                                      input logic [`EXEC_XLEN-1:0] b);
    vec_t v;
    v           = '0;
    v.a         = a;
    v.b         = b;
    v.exp_wdata = ref_result(kind, a, b);
    case (kind)
      2'd0: begin
        v.unit = U_ALU;
        v.op   = exec_pkg::ALU_ADD;
      end
      2'd1: begin
        v.unit = U_ALU;
        v.op   = exec_pkg::ALU_XOR;
      end
      2'd2: begin
        v.unit = U_MUL;
        v.op   = 4'd0;
      end
      default: begin
        v.unit = U_DIV;
        v.op   = 4'd1;
      end
    endcase
    return v;
  endfunction

  ////////////////////
  // Row driver
  ////////////////////

  task automatic run_row(input vec_t v, input int idx);
    exec_pkg::ex_wb_pipe_t snap;
    @(posedge clk);
    id_ex_pipe_i <= make_pipe(v, idx);
    wb_ready_i   <= (v.stall == '0);
    @(negedge clk);
    snap = ex_wb_pipe_o;
    if (v.unit == U_ALU) begin
      check_branch(branch_decision_o, v.exp_branch, "branch decision in issue cycle");
      check_flag(ex_valid_o, 1'b1, "ALU ex_valid_o in issue cycle");
    end
    // WB stalled for the first cycles of the row
    for (int i = 0; i < int'(v.stall); i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_flag(ex_ready_o, 1'b0, "ex_ready_o under back-pressure");
      check_wb(ex_wb_pipe_o, snap, "EX/WB held under back-pressure");
    end
    if (v.stall != '0) begin
      @(posedge clk);
      wb_ready_i <= 1'b1;
      @(negedge clk);
    end
    if (v.kill) begin
      repeat (KILL_DELAY) @(negedge clk);
      check_flag(ex_ready_o, 1'b0, "ex_ready_o while dividing");
      @(posedge clk);
      ctrl_fsm_i.kill_ex <= 1'b1;
      @(negedge clk);
      check_flag(ex_ready_o, 1'b1, "ex_ready_o under kill");
      @(posedge clk);
      ctrl_fsm_i   <= '0;
      id_ex_pipe_i <= '0;
      // Units idle again and nothing reaches WB
      repeat (KILL_WAIT) begin
        @(negedge clk);
        check_flag(ex_ready_o, 1'b1, "ex_ready_o after kill");
        check_flag(ex_wb_pipe_o.instr_valid, 1'b0, "EX/WB valid after kill");
      end
    end else begin
      while (!ex_ready_o) begin
        @(negedge clk);
      end
      // Result is on the forwarding path before the EX/WB edge
      check_wdata(rf_wdata_o, v.exp_wdata, "forwarded rf_wdata_o");
      @(posedge clk);
      id_ex_pipe_i <= '0;
      @(negedge clk);
      while (!ex_wb_pipe_o.instr_valid) begin
        @(negedge clk);
      end
      check_wb(ex_wb_pipe_o, expected_wb(v, idx), "result in EX/WB");
    end
  endtask

  initial begin
    logic [`EXEC_XLEN-1:0] r;
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    seed         = 67138;
    rst_n        = 1'b0;
    id_ex_pipe_i = '0;
    ctrl_fsm_i   = '0;
    wb_ready_i   = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag(ex_valid_o, 1'b0, "ex_valid_o after reset");
    check_flag(ex_wb_pipe_o.instr_valid, 1'b0, "EX/WB valid after reset");
    for (int i = 0; i < NUM_VEC; i++) begin
      run_row(VECS[i], i);
    end
    // Random add, xor, mul and divu
    for (int k = 0; k < NUM_RAND; k++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      run_row(random_row(r[1:0], a, b), NUM_VEC + k);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule
